//--- mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// First instruction address after reset.
`define MIPS_RESET_VECTOR 32'hBFC00000

// A jump that lands here stops the CPU.
`define MIPS_HALT_ADDR 32'h00000000

// Architectural register numbers.
`define MIPS_REG_V0 5'd2
`define MIPS_REG_V3 5'd3
`define MIPS_REG_RA 5'd31

`endif

//--- mips_pkg.sv
`default_nettype none

package mips_pkg;

  // One machine word.
  typedef logic [31:0] word_t;

  // Register format.
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_fmt_t;

  // Immediate format.
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } i_fmt_t;

  // Jump format.
  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] target;
  } j_fmt_t;

  // The same instruction word seen in each of the three formats.
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    j_fmt_t j_fmt;
  } instr_u;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_LUI
  } alu_op_t;

  // Access width; signedness only matters for byte loads.
  typedef enum logic [1:0] {
    MEM_WORD,
    MEM_BYTE_S,
    MEM_BYTE_U
  } mem_kind_t;

  typedef struct packed {
    // Write strobes.
    logic      pc_we;
    logic      ir_we;
    logic      reg_we;
    // ALU control.
    alu_op_t   alu_op;
    logic      src_b_imm;
    logic      imm_zero_ext;
    // Write-back selection.
    logic      dest_rd;
    logic      dest_ra;
    logic      result_from_mem;
    // Branch and jump.
    logic      branch;
    logic      branch_ne;
    logic      jump;
    logic      jump_reg;
    // Memory request.
    mem_kind_t mem_kind;
    logic      mem_read;
    logic      mem_write;
    logic      use_data_addr;
  } ctrl_t;

endpackage

`default_nettype wire

//--- mips_alu.sv
`timescale 1ns/1ns
`default_nettype none

module mips_alu (
  input  mips_pkg::alu_op_t op,
  input  mips_pkg::word_t   a,
  input  mips_pkg::word_t   b,
  input  logic [4:0]        shamt,
  output mips_pkg::word_t   y,
  output logic              zero
);

  import mips_pkg::*;

  always_comb begin
    case (op)
      ALU_ADD: y = a + b;
      ALU_SUB: y = a - b;
      ALU_AND: y = a & b;
      ALU_OR:  y = a | b;
      ALU_XOR: y = a ^ b;
      // Signed compare, result in bit 0.
      ALU_SLT: y = {31'b0, $signed(a) < $signed(b)};
      // Shifts act on rt, amount from the shamt field.
      ALU_SLL: y = b << shamt;
      ALU_SRL: y = b >> shamt;
      // Immediate goes to the upper half.
      ALU_LUI: y = {b[15:0], 16'h0000};
      default: y = '0;
    endcase
  end

  // Used by beq and bne after a subtract.
  assign zero = (y == '0);

endmodule

`default_nettype wire

//--- mips_regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_macros.svh"

module mips_regfile (
  input  logic            clk,
  input  logic            reset,
  input  logic [4:0]      ra,
  input  logic [4:0]      rb,
  input  logic [4:0]      wa,
  input  logic            we,
  input  mips_pkg::word_t wd,
  output mips_pkg::word_t rda,
  output mips_pkg::word_t rdb,
  output mips_pkg::word_t v0,
  output mips_pkg::word_t v3
);

  import mips_pkg::*;

  word_t regs [0:31];

  // Register 0 never takes a write, so it reads as zero.
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int k = 0; k < 32; k++) begin
        regs[k] <= '0;
      end
    end else if (we && (wa != 5'd0)) begin
      regs[wa] <= wd;
    end
  end

  // Combinational read ports.
  assign rda = regs[ra];
  assign rdb = regs[rb];

  // Observation taps
  assign v0 = regs[`MIPS_REG_V0];
  assign v3 = regs[`MIPS_REG_V3];

endmodule

`default_nettype wire

//--- mips_datapath.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_macros.svh"

module mips_datapath (
  input  logic             clk,
  input  logic             reset,
  input  mips_pkg::ctrl_t  ctrl,
  input  mips_pkg::word_t  load_data,
  input  logic             mem_done,
  output mips_pkg::instr_u instr,
  output logic             zero,
  output mips_pkg::word_t  pc,
  output mips_pkg::word_t  data_addr,
  output mips_pkg::word_t  store_data,
  output logic             pc_next_is_halt,
  output mips_pkg::word_t  register_v0,
  output mips_pkg::word_t  register_v3
);

  import mips_pkg::*;

  word_t      a_q, b_q, alu_q, mdr;
  word_t      rda, rdb, alu_y, src_b, imm_ext;
  word_t      br_target, j_target, pc_next, wd;
  logic [4:0] wa;

  // PC and IR; IR clears to a nop so the parked WB state writes nothing.
  always_ff @(posedge clk) begin
    if (reset) begin
      pc    <= `MIPS_RESET_VECTOR;
      instr <= '0;
    end else begin
      if (ctrl.pc_we) begin
        pc <= pc_next;
      end
      if (ctrl.ir_we) begin
        instr <= load_data;
      end
    end
  end

  // Operand and result registers follow their sources every cycle.
  // They hold steady while IR does.
  always_ff @(posedge clk) begin
    a_q   <= rda;
    b_q   <= rdb;
    alu_q <= alu_y;
    if (mem_done && ctrl.use_data_addr) begin
      mdr <= load_data;
    end
  end

  // Sign or zero extension.
  assign imm_ext = ctrl.imm_zero_ext ? {16'h0000, instr.i_fmt.imm}
                                     : {{16{instr.i_fmt.imm[15]}}, instr.i_fmt.imm};
  assign src_b   = ctrl.src_b_imm ? imm_ext : b_q;

  // PC already points past the branch, so the offset is added to it.
  assign br_target = pc + {{14{instr.i_fmt.imm[15]}}, instr.i_fmt.imm, 2'b00};
  assign j_target  = {pc[31:28], instr.j_fmt.target, 2'b00};

  // Branch target is only written when the branch is taken.
  always_comb begin
    if (ctrl.jump_reg) begin
      pc_next = a_q;
    end else if (ctrl.jump) begin
      pc_next = j_target;
    end else if (ctrl.branch) begin
      pc_next = br_target;
    end else begin
      pc_next = pc + 32'd4;
    end
  end

  assign pc_next_is_halt = (pc_next == `MIPS_HALT_ADDR);

  // Destination register select.
  always_comb begin
    if (ctrl.dest_ra) begin
      wa = `MIPS_REG_RA;
    end else if (ctrl.dest_rd) begin
      wa = instr.r_fmt.rd;
    end else begin
      wa = instr.i_fmt.rt;
    end
  end

  assign wd = ctrl.result_from_mem ? mdr : alu_q;

  // Effective address and store value for the bus unit.
  assign data_addr  = alu_q;
  assign store_data = b_q;

  mips_regfile u_regfile (
    .clk   (clk),
    .reset (reset),
    .ra    (instr.r_fmt.rs),
    .rb    (instr.r_fmt.rt),
    .wa    (wa),
    .we    (ctrl.reg_we),
    .wd    (wd),
    .rda   (rda),
    .rdb   (rdb),
    .v0    (register_v0),
    .v3    (register_v3)
  );

  mips_alu u_alu (
    .op    (ctrl.alu_op),
    .a     (a_q),
    .b     (src_b),
    .shamt (instr.r_fmt.shamt),
    .y     (alu_y),
    .zero  (zero)
  );

endmodule

`default_nettype wire

//--- mips_controller.sv
`timescale 1ns/1ns
`default_nettype none

module mips_controller (
  input  logic             clk,
  input  logic             reset,
  input  mips_pkg::instr_u instr,
  input  logic             zero,
  input  logic             mem_done,
  input  logic             pc_next_is_halt,
  output mips_pkg::ctrl_t  ctrl,
  output logic             halted
);

  import mips_pkg::*;

  typedef enum logic [2:0] {
    S_FETCH,
    S_DECODE,
    S_EXEC,
    S_MEM,
    S_WB,
    S_HALT
  } state_t;

  state_t state, state_n;
  ctrl_t  dec;
  logic   taken;

  // Operation decode; reg_we, mem_read and mem_write mean "does this".
  // Unknown opcodes and functs leave everything clear and run as nops.
  always_comb begin
    dec          = '0;
    dec.alu_op   = ALU_ADD;
    dec.mem_kind = MEM_WORD;
    case (instr.r_fmt.opcode)
      6'h00: begin
        dec.dest_rd = 1'b1;
        dec.reg_we  = 1'b1;
        case (instr.r_fmt.funct)
          6'h21: dec.alu_op = ALU_ADD;
          6'h23: dec.alu_op = ALU_SUB;
          6'h24: dec.alu_op = ALU_AND;
          6'h25: dec.alu_op = ALU_OR;
          6'h26: dec.alu_op = ALU_XOR;
          6'h2A: dec.alu_op = ALU_SLT;
          6'h00: dec.alu_op = ALU_SLL;
          6'h02: dec.alu_op = ALU_SRL;
          6'h08: begin
            dec.reg_we   = 1'b0;
            dec.jump_reg = 1'b1;
          end
          default: dec.reg_we = 1'b0;
        endcase
      end
      6'h02: dec.jump = 1'b1;
      // beq and bne compare by subtracting.
      6'h04, 6'h05: begin
        dec.branch    = 1'b1;
        dec.branch_ne = instr.r_fmt.opcode[0];
        dec.alu_op    = ALU_SUB;
      end
      6'h09, 6'h0A, 6'h0C, 6'h0D, 6'h0E, 6'h0F: begin
        dec.reg_we       = 1'b1;
        dec.src_b_imm    = 1'b1;
        // Logic immediates are zero-extended.
        dec.imm_zero_ext = instr.r_fmt.opcode[2];
        case (instr.r_fmt.opcode[2:0])
          3'h1:    dec.alu_op = ALU_ADD;
          3'h2:    dec.alu_op = ALU_SLT;
          3'h4:    dec.alu_op = ALU_AND;
          3'h5:    dec.alu_op = ALU_OR;
          3'h6:    dec.alu_op = ALU_XOR;
          default: dec.alu_op = ALU_LUI;
        endcase
      end
      // lb, lbu, lw.
      6'h20, 6'h24, 6'h23: begin
        dec.reg_we          = 1'b1;
        dec.src_b_imm       = 1'b1;
        dec.mem_read        = 1'b1;
        dec.result_from_mem = 1'b1;
        case (instr.r_fmt.opcode[2:0])
          3'h0:    dec.mem_kind = MEM_BYTE_S;
          3'h4:    dec.mem_kind = MEM_BYTE_U;
          default: dec.mem_kind = MEM_WORD;
        endcase
      end
      // sb, sw.
      6'h28, 6'h2B: begin
        dec.src_b_imm = 1'b1;
        dec.mem_write = 1'b1;
        dec.mem_kind  = instr.r_fmt.opcode[0] ? MEM_WORD : MEM_BYTE_U;
      end
      default: ;
    endcase
  end

  // Per-state strobes on top of the decoded operation.
  always_comb begin
    ctrl  = '0;
    taken = 1'b0;
    case (state)
      S_FETCH: begin
        ctrl.mem_read = 1'b1;
        ctrl.ir_we    = mem_done;
        ctrl.pc_we    = mem_done;
      end
      S_EXEC: begin
        ctrl           = dec;
        ctrl.reg_we    = 1'b0;
        ctrl.mem_read  = 1'b0;
        ctrl.mem_write = 1'b0;
        taken = dec.jump | dec.jump_reg | (dec.branch & (zero ^ dec.branch_ne));
        ctrl.pc_we     = taken;
      end
      S_MEM: begin
        ctrl               = dec;
        ctrl.reg_we        = 1'b0;
        ctrl.use_data_addr = 1'b1;
      end
      S_WB: begin
        ctrl           = dec;
        ctrl.mem_read  = 1'b0;
        ctrl.mem_write = 1'b0;
      end
      default: ;
    endcase
  end

  always_comb begin
    state_n = state;
    case (state)
      S_FETCH:  if (mem_done) state_n = S_DECODE;
      S_DECODE: state_n = S_EXEC;
      S_EXEC: begin
        if (taken && pc_next_is_halt) begin
          state_n = S_HALT;
        end else if (dec.mem_read || dec.mem_write) begin
          state_n = S_MEM;
        end else begin
          state_n = S_WB;
        end
      end
      S_MEM:    if (mem_done) state_n = S_WB;
      S_WB:     state_n = S_FETCH;
      default:  state_n = S_HALT;
    endcase
  end

  // Reset parks in WB, so the first fetch starts one edge after release.
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= S_WB;
    end else begin
      state <= state_n;
    end
  end

  // Flagged as the halting PC write is committed.
  assign halted = (state_n == S_HALT);

  a_state_legal : assert property (@(posedge clk) disable iff (reset)
    state inside {S_FETCH, S_DECODE, S_EXEC, S_MEM, S_WB, S_HALT});

endmodule

`default_nettype wire

//--- mips_bus_unit.sv
`timescale 1ns/1ns
`default_nettype none

module mips_bus_unit (
  input  logic            clk,
  input  logic            reset,
  input  mips_pkg::ctrl_t ctrl,
  input  mips_pkg::word_t pc,
  input  mips_pkg::word_t data_addr,
  input  mips_pkg::word_t store_data,
  output mips_pkg::word_t load_data,
  output logic            mem_done,
  output mips_pkg::word_t address,
  output logic            write,
  output logic            read,
  input  logic            waitrequest,
  output mips_pkg::word_t writedata,
  output logic [3:0]      byteenable,
  input  mips_pkg::word_t readdata
);

  import mips_pkg::*;

  word_t      req_addr, cpu_rdata, cpu_wdata;
  logic [1:0] offset;
  logic [7:0] load_byte;
  logic       is_byte;

  // Big-endian CPU word against little-endian bus word.
  function automatic word_t swap_bytes(input word_t w);
    swap_bytes = {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  // Request held by the controller until the transfer completes.
  assign req_addr = ctrl.use_data_addr ? data_addr : pc;
  assign offset   = req_addr[1:0];
  assign address  = {req_addr[31:2], 2'b00};
  assign read     = ctrl.mem_read;
  assign write    = ctrl.mem_write;
  assign mem_done = (read | write) & ~waitrequest;

  // CPU byte offset k sits on bus lane 3 - k.
  assign is_byte    = (ctrl.mem_kind != MEM_WORD);
  assign byteenable = is_byte ? (4'b0001 << ~offset) : 4'b1111;

  // sb puts the byte on every lane; byteenable picks one
  assign cpu_wdata = is_byte ? {4{store_data[7:0]}} : store_data;
  assign writedata = swap_bytes(cpu_wdata);

  assign cpu_rdata = swap_bytes(readdata);
  assign load_byte = cpu_rdata[8*offset +: 8];

  always_comb begin
    case (ctrl.mem_kind)
      MEM_BYTE_S: load_data = {{24{load_byte[7]}}, load_byte};
      MEM_BYTE_U: load_data = {24'h000000, load_byte};
      default:    load_data = cpu_rdata;
    endcase
  end

  a_no_rd_wr : assert property (@(posedge clk) disable iff (reset) !(read && write));

  // A stalled request keeps its address and stays raised.
  a_hold_req : assert property (@(posedge clk) disable iff (reset)
    (read || write) && waitrequest |=> $stable(address) && (read || write));

endmodule

`default_nettype wire

//--- mips_cpu_harvard.sv
`timescale 1ns/1ns
`default_nettype none

module mips_cpu_harvard (
  input  logic            clk,
  input  logic            reset,
  output logic            active,
  output mips_pkg::word_t register_v0,
  output mips_pkg::word_t register_v3,
  output mips_pkg::word_t address,
  output logic            write,
  output logic            read,
  input  logic            waitrequest,
  output mips_pkg::word_t writedata,
  output logic [3:0]      byteenable,
  input  mips_pkg::word_t readdata
);

  import mips_pkg::*;

  ctrl_t  ctrl;
  instr_u instr;
  word_t  pc, data_addr, store_data, load_data;
  logic   zero, mem_done, pc_next_is_halt, halted;

  mips_controller u_controller (
    .clk             (clk),
    .reset           (reset),
    .instr           (instr),
    .zero            (zero),
    .mem_done        (mem_done),
    .pc_next_is_halt (pc_next_is_halt),
    .ctrl            (ctrl),
    .halted          (halted)
  );

  mips_datapath u_datapath (
    .clk             (clk),
    .reset           (reset),
    .ctrl            (ctrl),
    .load_data       (load_data),
    .mem_done        (mem_done),
    .instr           (instr),
    .zero            (zero),
    .pc              (pc),
    .data_addr       (data_addr),
    .store_data      (store_data),
    .pc_next_is_halt (pc_next_is_halt),
    .register_v0     (register_v0),
    .register_v3     (register_v3)
  );

  mips_bus_unit u_bus_unit (
    .clk         (clk),
    .reset       (reset),
    .ctrl        (ctrl),
    .pc          (pc),
    .data_addr   (data_addr),
    .store_data  (store_data),
    .load_data   (load_data),
    .mem_done    (mem_done),
    .address     (address),
    .write       (write),
    .read        (read),
    .waitrequest (waitrequest),
    .writedata   (writedata),
    .byteenable  (byteenable),
    .readdata    (readdata)
  );

  // Drops with the halting PC write and stays low until reset.
  always_ff @(posedge clk) begin
    if (reset) begin
      active <= 1'b1;
    end else if (halted) begin
      active <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- mips_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module mips_mem_model (
  input  logic            clk,
  input  logic            clear,
  input  logic            load_en,
  input  logic [11:0]     load_addr,
  input  mips_pkg::word_t load_word,
  input  logic [1:0]      stall_len,
  input  mips_pkg::word_t address,
  input  logic            read,
  input  logic            write,
  input  logic [3:0]      byteenable,
  input  mips_pkg::word_t writedata,
  output mips_pkg::word_t readdata,
  output logic            waitrequest,
  output logic            bad_byteenable
);

  import mips_pkg::*;

  word_t       words [0:4095];
  word_t       merged;
  logic [11:0] index;
  logic        request;
  logic        pending;
  logic [1:0]  wait_left;
  int          k;

  // Upper address bits are not decoded.
  // The reset vector therefore lands on word 0.
  assign index    = address[13:2];
  assign request  = read | write;
  assign readdata = words[index];

  // Enabled lanes take the new byte, the others keep the stored one.
  assign merged = {byteenable[3] ? writedata[31:24] : readdata[31:24],
                   byteenable[2] ? writedata[23:16] : readdata[23:16],
                   byteenable[1] ? writedata[15:8]  : readdata[15:8],
                   byteenable[0] ? writedata[7:0]   : readdata[7:0]};

  // Stall length is sampled on the first cycle of a request.
  assign waitrequest = request && (pending ? (wait_left != 2'd0) : (stall_len != 2'd0));

  // Counts down the remaining stall cycles of a held request.
  always @(posedge clk) begin
    if (clear) begin
      pending   <= 1'b0;
      wait_left <= 2'd0;
    end else if (request && !pending && (stall_len != 2'd0)) begin
      pending   <= 1'b1;
      wait_left <= stall_len - 2'd1;
    end else if (pending && (wait_left != 2'd0)) begin
      wait_left <= wait_left - 2'd1;
    end else begin
      // Transfer completes on this edge.
      pending <= 1'b0;
    end
  end

  // Clear, program load and bus writes share one port.
  always @(posedge clk) begin
    if (clear) begin
      // Unloaded words hold a value unique to their index.
      for (k = 0; k < 4096; k++) begin
        words[k] <= {4'hD, k[11:0], 4'hE, ~k[11:0]};
      end
      bad_byteenable <= 1'b0;
    end else if (load_en) begin
      words[load_addr] <= load_word;
    end else if (write && !waitrequest) begin
      words[index] <= merged;
      // Only a full word or a single byte lane is legal.
      case (byteenable)
        4'b1111, 4'b0001, 4'b0010, 4'b0100, 4'b1000: ;
        default: bad_byteenable <= 1'b1;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- mips_cpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_macros.svh"

module mips_cpu_tb;

  import mips_pkg::*;

  localparam int NUM_PROGS    = 5;
  localparam int NUM_ROWS     = 8;
  localparam int MAX_WORDS    = 12;
  localparam int RESET_CYCLES = 16;
  localparam int IDLE_CYCLES  = 8;
  localparam int TIMEOUT      = NUM_ROWS * 400;
  localparam int SEED         = 98743;

  // MIPS-I opcodes.
  localparam logic [5:0] OP_BEQ   = 6'h04;
  localparam logic [5:0] OP_BNE   = 6'h05;
  localparam logic [5:0] OP_ADDIU = 6'h09;
  localparam logic [5:0] OP_SLTI  = 6'h0A;
  localparam logic [5:0] OP_ANDI  = 6'h0C;
  localparam logic [5:0] OP_ORI   = 6'h0D;
  localparam logic [5:0] OP_XORI  = 6'h0E;
  localparam logic [5:0] OP_LUI   = 6'h0F;
  localparam logic [5:0] OP_LB    = 6'h20;
  localparam logic [5:0] OP_LW    = 6'h23;
  localparam logic [5:0] OP_LBU   = 6'h24;
  localparam logic [5:0] OP_SB    = 6'h28;
  localparam logic [5:0] OP_SW    = 6'h2B;

  // R-type funct codes.
  localparam logic [5:0] F_SLL  = 6'h00;
  localparam logic [5:0] F_SRL  = 6'h02;
  localparam logic [5:0] F_JR   = 6'h08;
  localparam logic [5:0] F_ADDU = 6'h21;
  localparam logic [5:0] F_SUBU = 6'h23;
  localparam logic [5:0] F_AND  = 6'h24;
  localparam logic [5:0] F_OR   = 6'h25;
  localparam logic [5:0] F_XOR  = 6'h26;
  localparam logic [5:0] F_SLT  = 6'h2A;

  logic        clk;
  logic        reset;
  logic        active;
  logic        write;
  logic        read;
  logic        waitrequest;
  logic [3:0]  byteenable;
  word_t       register_v0;
  word_t       register_v3;
  word_t       address;
  word_t       writedata;
  word_t       readdata;

  // Memory model control.
  logic        clear;
  logic        load_en;
  logic [11:0] load_addr;
  word_t       load_word;
  logic [1:0]  stall_len;
  logic        bad_byteenable;

  // Program table, expected results and row schedule.
  word_t       prog [NUM_PROGS][MAX_WORDS];
  int          prog_len [NUM_PROGS];
  word_t       exp_v0 [NUM_PROGS];
  word_t       exp_v3 [NUM_PROGS];
  int          row_prog [NUM_ROWS];
  logic        row_stall [NUM_ROWS];

  int          stall_cycles;
  int          cycle_count = 0;

  mips_cpu_harvard UUT (
    .clk         (clk),
    .reset       (reset),
    .active      (active),
    .register_v0 (register_v0),
    .register_v3 (register_v3),
    .address     (address),
    .write       (write),
    .read        (read),
    .waitrequest (waitrequest),
    .writedata   (writedata),
    .byteenable  (byteenable),
    .readdata    (readdata)
  );

  mips_mem_model u_mem (
    .clk            (clk),
    .clear          (clear),
    .load_en        (load_en),
    .load_addr      (load_addr),
    .load_word      (load_word),
    .stall_len      (stall_len),
    .address        (address),
    .read           (read),
    .write          (write),
    .byteenable     (byteenable),
    .writedata      (writedata),
    .readdata       (readdata),
    .waitrequest    (waitrequest),
    .bad_byteenable (bad_byteenable)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input word_t got, input word_t expected, input string name);
    if (got !== expected) begin
      fail_now($sformatf("MISMATCH at %0t: %s is %h, expected %h",
                         $time, name, got, expected));
    end
  endtask

  task automatic check_bit(input logic got, input logic expected, input string name);
    if (got !== expected) begin
      fail_now($sformatf("MISMATCH at %0t: %s is %b, expected %b",
                         $time, name, got, expected));
    end
  endtask

  // Instruction encoders.
  function automatic word_t r_type(input logic [4:0] rs, rt, rd, shamt,
                                   input logic [5:0] funct);
    return {6'h00, rs, rt, rd, shamt, funct};
  endfunction

  function automatic word_t i_type(input logic [5:0] op, input logic [4:0] rs, rt,
                                   input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // j to a word of the program, which sits at the reset vector.
  function automatic word_t j_type(input int index);
    word_t dest;
    dest = `MIPS_RESET_VECTOR + 4 * index;
    return {6'h02, dest[27:2]};
  endfunction

  // Big-endian CPU word to little-endian bus word.
  function automatic word_t to_bus_order(input word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  task automatic add_instr(input int p, input word_t w);
    prog[p][prog_len[p]] = w;
    prog_len[p]++;
  endtask

  task automatic build_table();
    int p;
    int i;
    for (p = 0; p < NUM_PROGS; p++) begin
      prog_len[p] = 0;
      for (i = 0; i < MAX_WORDS; i++) begin
        prog[p][i] = '0;
      end
    end
    // Arithmetic with a sign-extended immediate.
    add_instr(0, i_type(OP_ADDIU, 0, 4, 16'h1234));
    add_instr(0, i_type(OP_ADDIU, 0, 5, 16'hFFF0));
    add_instr(0, r_type(4, 5, `MIPS_REG_V0, 0, F_ADDU));
    add_instr(0, r_type(4, 5, `MIPS_REG_V3, 0, F_SUBU));
    add_instr(0, r_type(0, 0, 0, 0, F_JR));
    exp_v0[0] = 32'h00001224;
    exp_v3[0] = 32'h00001244;
    // Logic ops; logic immediates are zero-extended.
    add_instr(1, i_type(OP_LUI, 0, 4, 16'hF0F0));
    add_instr(1, i_type(OP_ORI, 4, 4, 16'h00FF));
    add_instr(1, i_type(OP_ADDIU, 0, 5, 16'h0FF0));
    add_instr(1, r_type(4, 5, 6, 0, F_AND));
    add_instr(1, r_type(4, 5, 7, 0, F_OR));
    add_instr(1, r_type(6, 7, `MIPS_REG_V0, 0, F_XOR));
    add_instr(1, i_type(OP_ANDI, 4, `MIPS_REG_V3, 16'hFF0F));
    add_instr(1, i_type(OP_XORI, `MIPS_REG_V3, `MIPS_REG_V3, 16'h8000));
    add_instr(1, r_type(0, 0, 0, 0, F_JR));
    exp_v0[1] = 32'hF0F00F0F;
    exp_v3[1] = 32'h0000800F;
    // Signed compares, logical shifts and a write to register 0.
    add_instr(2, i_type(OP_ADDIU, 0, 4, 16'hFFFF));
    add_instr(2, i_type(OP_ADDIU, 0, 5, 16'h0001));
    add_instr(2, r_type(4, 5, 6, 0, F_SLT));
    add_instr(2, r_type(5, 4, 7, 0, F_SLT));
    add_instr(2, r_type(0, 4, 8, 4, F_SLL));
    add_instr(2, r_type(0, 8, 8, 8, F_SRL));
    add_instr(2, r_type(8, 6, 8, 0, F_ADDU));
    add_instr(2, r_type(8, 7, `MIPS_REG_V0, 0, F_ADDU));
    add_instr(2, i_type(OP_SLTI, 4, 9, 16'h0000));
    add_instr(2, i_type(OP_ADDIU, 0, 0, 16'h0055));
    add_instr(2, r_type(9, 0, `MIPS_REG_V3, 0, F_ADDU));
    add_instr(2, r_type(0, 0, 0, 0, F_JR));
    exp_v0[2] = 32'h01000000;
    exp_v3[2] = 32'h00000001;
    // sw, sb into byte offset 1, then lw, lb and lbu.
    // Offset 1 is bus lane 2, which is CPU bits 15:8.
    add_instr(3, i_type(OP_ADDIU, 0, 4, 16'h0100));
    add_instr(3, i_type(OP_LUI, 0, 5, 16'h1122));
    add_instr(3, i_type(OP_ORI, 5, 5, 16'h3344));
    add_instr(3, i_type(OP_SW, 4, 5, 16'h0000));
    add_instr(3, i_type(OP_ADDIU, 0, 6, 16'h00A5));
    add_instr(3, i_type(OP_SB, 4, 6, 16'h0001));
    add_instr(3, i_type(OP_LW, 4, `MIPS_REG_V0, 16'h0000));
    add_instr(3, i_type(OP_LB, 4, 7, 16'h0001));
    add_instr(3, i_type(OP_LBU, 4, 8, 16'h0001));
    add_instr(3, r_type(7, 8, `MIPS_REG_V3, 0, F_ADDU));
    add_instr(3, r_type(0, 0, 0, 0, F_JR));
    exp_v0[3] = 32'h1122A544;
    exp_v3[3] = 32'h0000004A;
    // Branches and j; every skipped addiu would add a distinct bit to v3.
    add_instr(4, i_type(OP_ADDIU, 0, `MIPS_REG_V0, 16'h0001));
    add_instr(4, i_type(OP_BEQ, `MIPS_REG_V0, 0, 16'h0001));
    add_instr(4, i_type(OP_ADDIU, `MIPS_REG_V3, `MIPS_REG_V3, 16'h0010));
    add_instr(4, i_type(OP_BNE, `MIPS_REG_V0, 0, 16'h0001));
    add_instr(4, i_type(OP_ADDIU, `MIPS_REG_V3, `MIPS_REG_V3, 16'h0100));
    add_instr(4, i_type(OP_BEQ, `MIPS_REG_V0, `MIPS_REG_V0, 16'h0001));
    add_instr(4, i_type(OP_ADDIU, `MIPS_REG_V3, `MIPS_REG_V3, 16'h1000));
    add_instr(4, i_type(OP_BNE, `MIPS_REG_V3, `MIPS_REG_V3, 16'h0001));
    add_instr(4, i_type(OP_ADDIU, `MIPS_REG_V3, `MIPS_REG_V3, 16'h0002));
    add_instr(4, j_type(11));
    add_instr(4, i_type(OP_ADDIU, `MIPS_REG_V3, `MIPS_REG_V3, 16'h2000));
    add_instr(4, r_type(0, 0, 0, 0, F_JR));
    exp_v0[4] = 32'h00000001;
    exp_v3[4] = 32'h00000012;
    // Every program stall-free, then three again with random stalls.
    for (i = 0; i < NUM_PROGS; i++) begin
      row_prog[i]  = i;
      row_stall[i] = 1'b0;
    end
    row_prog[5]  = 1;
    row_stall[5] = 1'b1;
    row_prog[6]  = 3;
    row_stall[6] = 1'b1;
    row_prog[7]  = 4;
    row_stall[7] = 1'b1;
  endtask

  // Reset for 16 cycles; memory is cleared, then the program is loaded.
  task automatic load_and_reset(input int p);
    int k;
    for (k = 0; k < RESET_CYCLES; k++) begin
      @(posedge clk);
      reset   <= 1'b1;
      clear   <= (k == 0);
      load_en <= (k >= 1) && (k <= prog_len[p]);
      if ((k >= 1) && (k <= prog_len[p])) begin
        load_addr <= k - 1;
        load_word <= to_bus_order(prog[p][k - 1]);
      end
      @(negedge clk);
      // Bus stays idle and active high while reset is held.
      if (k > 0) begin
        check_bit(read, 1'b0, "read");
        check_bit(write, 1'b0, "write");
        check_bit(active, 1'b1, "active");
      end
    end
    @(posedge clk);
    reset   <= 1'b0;
    clear   <= 1'b0;
    load_en <= 1'b0;
  endtask

  // One random stall draw per cycle, all from this seeded thread.
  task automatic run_to_halt(input logic stalls);
    logic [1:0] draw;
    stall_cycles = 0;
    while (active) begin
      @(posedge clk);
      draw = $urandom_range(3, 0);
      stall_len <= stalls ? draw : 2'd0;
      @(negedge clk);
      if (waitrequest) begin
        stall_cycles++;
      end
      // Set on the edge of a write whose lanes are neither a word nor one byte.
      if (bad_byteenable) begin
        fail_now("A write reached memory with a byteenable that is not a word or one byte.");
      end
    end
    @(posedge clk);
    stall_len <= 2'd0;
  endtask

  // After halt the CPU stays inactive and makes no bus request.
  task automatic check_idle();
    int k;
    for (k = 0; k < IDLE_CYCLES; k++) begin
      @(negedge clk);
      check_bit(active, 1'b0, "active");
      check_bit(read, 1'b0, "read");
      check_bit(write, 1'b0, "write");
    end
  endtask

  initial begin
    int row;
    int unsigned seed_draw;
    reset     = 1'b1;
    clear     = 1'b0;
    load_en   = 1'b0;
    load_addr = '0;
    load_word = '0;
    stall_len = 2'd0;
    seed_draw = $urandom(SEED);
    build_table();
    for (row = 0; row < NUM_ROWS; row++) begin
      load_and_reset(row_prog[row]);
      run_to_halt(row_stall[row]);
      @(negedge clk);
      check_word(register_v0, exp_v0[row_prog[row]], "register_v0");
      check_word(register_v3, exp_v3[row_prog[row]], "register_v3");
      check_bit(active, 1'b0, "active");
      if (row_stall[row] && (stall_cycles == 0)) begin
        fail_now("A stall row ran to halt without a single waitrequest stall.");
      end
      check_idle();
    end
    $display("SIMULATION PASSED");
    $finish;
  end

  // Hang guard over the whole run.
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT) begin
      fail_now($sformatf("Timeout after %0d cycles, the CPU never halted.", cycle_count));
    end
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+.
mips_pkg.sv
mips_alu.sv
mips_regfile.sv
mips_datapath.sv
mips_controller.sv
mips_bus_unit.sv
mips_cpu_harvard.sv
mips_mem_model.sv
mips_cpu_tb.sv
